/* common/scope_pkg.sv */
package scope_pkg;

    // Decimation window
    localparam int unsigned decim_len = 32;
    localparam int unsigned decim_w = $clog2(decim_len);
    localparam logic [decim_w-1:0] decim_last = decim_w'(decim_len - 1);

    // Capture buffer
    localparam int unsigned capture_depth = 8;
    localparam int unsigned addr_w = $clog2(capture_depth);

    // Clocks per UART bit, short for simulation
    localparam int unsigned bit_cycles = 16;

    typedef logic [7:0] sample_t;
    typedef logic [7:0] byte_t;
    typedef logic [addr_w-1:0] addr_t;

    localparam addr_t addr_last = addr_t'(capture_depth - 1);

    localparam byte_t cmd_dump = 8'h64; // ASCII d
    localparam byte_t char_space = 8'h20;
    localparam byte_t char_cr = 8'h0d;
    localparam byte_t char_lf = 8'h0a;

endpackage

/* digitizer/digitizer.sv */
`timescale 1ns/1ps

module digitizer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               lvds_in,
    output logic               comp_in,
    output scope_pkg::sample_t sample,
    output logic               sample_valid
);

    logic [1:0] sync_q;
    logic lvds_s;
    logic [scope_pkg::decim_w-1:0] win_cnt;
    scope_pkg::sample_t ones;
    logic win_end;

    assign lvds_s = sync_q[1];
    assign comp_in = ~lvds_s; // Feedback to comparator
    assign win_end = (win_cnt == scope_pkg::decim_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11; // Keeps comp_in low in reset
        end else begin
            sync_q <= {sync_q[0], lvds_in};
        end
    end

    // Window counter and ones accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= '0;
            ones <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= win_end;
            if (win_end) begin
                win_cnt <= '0;
                ones <= '0; // Next window starts empty
            end else begin
                win_cnt <= win_cnt + 1'b1;
                ones <= ones + scope_pkg::sample_t'(lvds_s);
            end
        end
    end

    // Last bit of the window folded in here
    always_ff @(posedge clk) begin
        if (win_end) begin
            sample <= ones + scope_pkg::sample_t'(lvds_s);
        end
    end

endmodule

/* design/acia_rx.sv */
`timescale 1ns/1ps

module acia_rx #(
    parameter int baud = scope_pkg::bit_cycles
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx_serial,
    output scope_pkg::byte_t rx_dat,
    output logic             rx_stb,
    output logic             rx_err
);

    localparam int cw = $clog2(baud);
    localparam logic [cw-1:0] cnt_last = cw'(baud - 1);
    localparam logic [cw-1:0] cnt_half = cw'(baud / 2 - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t state;
    logic [1:0] sync_q;
    logic rx_s;
    logic [cw-1:0] cnt;
    logic [2:0] bit_idx;
    logic bit_tick;
    scope_pkg::byte_t shift;

    assign rx_s = sync_q[1];
    assign bit_tick = (cnt == cnt_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
            state <= st_idle;
            cnt <= '0;
            bit_idx <= '0;
            rx_stb <= 1'b0;
            rx_err <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], rx_serial};
            rx_stb <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= st_start; // Falling edge seen
                    end
                end
                st_start: begin
                    if (cnt == cnt_half) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_s ? st_idle : st_data; // Glitch rejected
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        state <= st_idle;
                        if (rx_s) begin
                            rx_stb <= 1'b1;
                            rx_err <= 1'b0;
                        end else begin
                            rx_err <= 1'b1; // Framing error
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == st_data && bit_tick) begin
            shift <= {rx_s, shift[7:1]};
        end
        if (state == st_stop && bit_tick && rx_s) begin
            rx_dat <= shift;
        end
    end

endmodule

/* design/acia_tx.sv */
`timescale 1ns/1ps

module acia_tx #(
    parameter int baud = scope_pkg::bit_cycles
) (
    input  logic             clk,
    input  logic             rst_n,
    input  scope_pkg::byte_t tx_dat,
    input  logic             tx_start,
    output logic             tx_serial,
    output logic             tx_busy
);

    localparam int cw = $clog2(baud);
    localparam logic [cw-1:0] cnt_last = cw'(baud - 1);

    logic [9:0] frame; // Stop, data, start
    logic [cw-1:0] cnt;
    logic [3:0] bit_idx;
    logic bit_tick;

    assign bit_tick = (cnt == cnt_last);
    assign tx_serial = frame[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame <= '1; // Line idles high
            cnt <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame <= {1'b1, tx_dat, 1'b0};
                cnt <= '0;
                bit_idx <= '0;
                tx_busy <= 1'b1;
            end
        end else if (bit_tick) begin
            cnt <= '0;
            frame <= {1'b1, frame[9:1]};
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0; // Stop bit done
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* design/sample_capture.sv */
`timescale 1ns/1ps

module sample_capture (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  scope_pkg::sample_t sample,
    input  logic               sample_valid,
    input  scope_pkg::addr_t   rd_addr,
    output scope_pkg::sample_t rd_data,
    output logic               full
);

    scope_pkg::sample_t mem [scope_pkg::capture_depth];
    scope_pkg::addr_t wr_addr;
    logic armed;
    logic wr_en;

    assign wr_en = armed && sample_valid && !start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed <= 1'b0;
            wr_addr <= '0;
            full <= 1'b0;
        end else if (start) begin
            armed <= 1'b1;
            wr_addr <= '0;
            full <= 1'b0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
            if (wr_addr == scope_pkg::addr_last) begin
                armed <= 1'b0; // Buffer complete
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= sample;
        end
        rd_data <= mem[rd_addr]; // One cycle read latency
    end

endmodule

/* hex_dump/hex_dump.sv */
`timescale 1ns/1ps

module hex_dump (
    input  logic               clk,
    input  logic               rst_n,
    input  scope_pkg::byte_t   rx_dat,
    input  logic               rx_stb,
    input  logic               full,
    output logic               start,
    output scope_pkg::addr_t   rd_addr,
    input  scope_pkg::sample_t rd_data,
    output scope_pkg::byte_t   tx_dat,
    output logic               tx_start,
    input  logic               tx_busy,
    output logic               busy
);

    typedef enum logic [3:0] {
        st_idle,
        st_arm,
        st_fetch,
        st_hi,
        st_lo,
        st_sp,
        st_cr,
        st_lf,
        st_wait
    } state_t;

    state_t state;
    state_t ret; // Where to go once the byte is out
    state_t nxt;
    scope_pkg::byte_t ch;
    logic send_st;
    logic send_go;

    function automatic scope_pkg::byte_t hex_char(input logic [3:0] nib);
        scope_pkg::byte_t c;
        if (nib < 4'd10) begin
            c = 8'h30 + {4'h0, nib};
        end else begin
            c = 8'h37 + {4'h0, nib}; // Upper-case A to F
        end
        return c;
    endfunction

    // Character and follow-up state for each send state
    always_comb begin
        send_st = 1'b1;
        ch = scope_pkg::char_lf;
        nxt = st_idle;
        case (state)
            st_hi: begin
                ch = hex_char(rd_data[7:4]);
                nxt = st_lo;
            end
            st_lo: begin
                ch = hex_char(rd_data[3:0]);
                nxt = st_sp;
            end
            st_sp: begin
                ch = scope_pkg::char_space;
                nxt = (rd_addr == scope_pkg::addr_last) ? st_cr : st_fetch;
            end
            st_cr: begin
                ch = scope_pkg::char_cr;
                nxt = st_lf;
            end
            st_lf: nxt = st_idle;
            default: send_st = 1'b0;
        endcase
    end

    assign send_go = send_st && !tx_busy;
    assign busy = (state != st_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ret <= st_idle;
            start <= 1'b0;
            tx_start <= 1'b0;
            rd_addr <= '0;
        end else begin
            start <= 1'b0;
            tx_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_stb && rx_dat == scope_pkg::cmd_dump) begin
                        start <= 1'b1;
                        state <= st_arm;
                    end
                end
                st_arm: begin
                    if (full && !start) begin // Old full still up during start
                        rd_addr <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch: state <= st_hi;
                st_wait: begin
                    // tx_busy only rises the cycle after tx_start
                    if (!tx_busy && !tx_start) begin
                        state <= ret;
                    end
                end
                default: begin
                    if (send_go) begin
                        tx_start <= 1'b1;
                        ret <= nxt;
                        state <= st_wait;
                        if (nxt == st_fetch) begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send_go) begin
            tx_dat <= ch;
        end
    end

endmodule

/* design/scope_top.sv */
`timescale 1ns/1ps

module scope_top (
    input  logic clk,
    input  logic rst_n,
    input  logic lvds_in,
    input  logic fpga_rx,
    output logic comp_in,
    output logic fpga_tx,
    output logic led_capture,
    output logic led_busy,
    output logic rx_err
);

    scope_pkg::sample_t sample;
    logic sample_valid;
    scope_pkg::byte_t rx_dat;
    logic rx_stb;
    logic start;
    scope_pkg::addr_t rd_addr;
    scope_pkg::sample_t rd_data;
    scope_pkg::byte_t tx_dat;
    logic tx_start;
    logic tx_busy;

    digitizer digitizer (
        .clk          (clk),
        .rst_n        (rst_n),
        .lvds_in      (lvds_in),
        .comp_in      (comp_in),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    acia_rx #(
        .baud (scope_pkg::bit_cycles)
    ) acia_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_serial (fpga_rx),
        .rx_dat    (rx_dat),
        .rx_stb    (rx_stb),
        .rx_err    (rx_err)
    );

    sample_capture sample_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .sample       (sample),
        .sample_valid (sample_valid),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .full         (led_capture)
    );

    hex_dump hex_dump (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_dat   (rx_dat),
        .rx_stb   (rx_stb),
        .full     (led_capture),
        .start    (start),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .tx_dat   (tx_dat),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .busy     (led_busy)
    );

    acia_tx #(
        .baud (scope_pkg::bit_cycles)
    ) acia_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_dat    (tx_dat),
        .tx_start  (tx_start),
        .tx_serial (fpga_tx),
        .tx_busy   (tx_busy)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 100,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // Released on a falling edge
    end

endmodule

/* tests/tb_scope.sv */
`timescale 1ns/1ps

module tb_scope;

    localparam int frame_cycles = 10 * scope_pkg::bit_cycles;
    localparam int dump_cycles = 26 * frame_cycles + 9 * scope_pkg::decim_len;
    localparam int byte_timeout = 2 * frame_cycles + 12 * scope_pkg::decim_len;

    logic clk;
    logic rst_n;
    logic lvds_in;
    logic fpga_rx;
    logic comp_in;
    logic fpga_tx;
    logic led_capture;
    logic led_busy;
    logic rx_err;

    logic [31:0] rng;
    int lvds_mode; // 0 hold, 1 random, 2 pattern
    int k_cur;
    int phase;
    logic prev1;
    logic prev2;
    string cur_test;
    int err_count;
    int test_errs;
    int pass_tests;
    int fail_tests;

    tb_clock #(.period(100), .reset_cycles(10)) clock_gen (.clk(clk), .rst_n(rst_n));

    scope_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .lvds_in     (lvds_in),
        .fpga_rx     (fpga_rx),
        .comp_in     (comp_in),
        .fpga_tx     (fpga_tx),
        .led_capture (led_capture),
        .led_busy    (led_busy),
        .rx_err      (rx_err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected dump text, two hex digits and a space per sample, then CR LF
    function automatic scope_pkg::byte_t line_char(input int k, input int idx);
        string digits;
        digits = "0123456789ABCDEF";
        if (idx == 24) return 8'h0d;
        if (idx == 25) return 8'h0a;
        case (idx % 3)
            0: return digits[k / 16];
            1: return digits[k % 16];
            default: return 8'h20;
        endcase
    endfunction

    // One clock, lvds_in updated after the falling edge
    task automatic tick();
        @(negedge clk);
        prev2 = prev1;
        prev1 = lvds_in;
        if (lvds_mode == 1) begin
            rng = xorshift32(rng);
            lvds_in = rng[0];
        end else if (lvds_mode == 2) begin
            lvds_in = (phase < k_cur); // k ones then zeros
            phase = (phase + 1) % scope_pkg::decim_len;
        end
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            tick();
        end
    endtask

    task automatic fail_check(input string msg);
        $display("error in %s: %s", cur_test, msg);
        err_count++;
    endtask

    task automatic check_byte(input string what, input scope_pkg::byte_t expected,
                              input scope_pkg::byte_t actual);
        if (actual !== expected) begin
            $display("mismatch %s %s expected %02h actual %02h", cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s %s expected %b actual %b", cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_errs) begin
            $display("test %s passed", cur_test);
            pass_tests++;
        end else begin
            $display("test %s failed with %0d errors", cur_test, err_count - test_errs);
            fail_tests++;
        end
    endtask

    // Host side 8N1 frame on fpga_rx
    task automatic send_byte(input scope_pkg::byte_t b, input logic stop_bit);
        fpga_rx = 1'b0;
        idle(scope_pkg::bit_cycles);
        for (int i = 0; i < 8; i++) begin
            fpga_rx = b[i];
            idle(scope_pkg::bit_cycles);
        end
        fpga_rx = stop_bit;
        idle(scope_pkg::bit_cycles);
        fpga_rx = 1'b1;
    endtask

    task automatic recv_byte(output scope_pkg::byte_t b, output logic ok);
        int n;
        n = 0;
        ok = 1'b0;
        b = '0;
        while (fpga_tx !== 1'b0 && n < byte_timeout) begin
            tick();
            n++;
        end
        if (fpga_tx !== 1'b0) begin
            fail_check("no start bit on fpga_tx before the timeout");
            return;
        end
        idle(scope_pkg::bit_cycles / 2); // To mid start bit
        if (fpga_tx !== 1'b0) begin
            fail_check("start bit on fpga_tx ended early");
            return;
        end
        for (int i = 0; i < 8; i++) begin
            idle(scope_pkg::bit_cycles);
            b[i] = fpga_tx;
        end
        idle(scope_pkg::bit_cycles);
        if (fpga_tx !== 1'b1) begin
            fail_check("stop bit on fpga_tx was low");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic recv_line(input int k);
        scope_pkg::byte_t b;
        logic ok;
        for (int i = 0; i < 26; i++) begin
            recv_byte(b, ok);
            if (!ok) begin
                return;
            end
            check_byte($sformatf("line byte %0d", i), line_char(k, i), b);
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (led_busy !== level && n < byte_timeout) begin
            tick();
            n++;
        end
        if (led_busy !== level) begin
            fail_check($sformatf("led_busy did not go to %b", level));
        end
    endtask

    task automatic wait_rx_err();
        int n;
        n = 0;
        while (rx_err !== 1'b1 && n < frame_cycles) begin
            tick();
            n++;
        end
        if (rx_err !== 1'b1) begin
            fail_check("rx_err did not rise after a bad stop bit");
        end
    endtask

    task automatic expect_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            tick();
            if (fpga_tx !== 1'b1) begin
                fail_check("unexpected frame on fpga_tx");
                return;
            end
            if (led_busy !== 1'b0) begin
                fail_check("a dump started without a valid command");
                return;
            end
        end
    endtask

    task automatic run_dump(input int k);
        begin_test($sformatf("dump_k%0d", k));
        k_cur = k;
        lvds_mode = 2;
        send_byte(scope_pkg::cmd_dump, 1'b1);
        recv_line(k);
        wait_busy(1'b0);
        check_bit("led_capture", 1'b1, led_capture);
        end_test();
    endtask

    initial begin
        scope_pkg::byte_t b;
        int n;
        rng = 32'h1a42_ec79;
        lvds_in = 1'b1;
        fpga_rx = 1'b1;
        lvds_mode = 0;
        k_cur = 0;
        phase = 0;
        prev1 = 1'b1;
        prev2 = 1'b1;
        err_count = 0;
        pass_tests = 0;
        fail_tests = 0;

        begin_test("reset_state");
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            tick();
            n++;
        end
        if (rst_n !== 1'b1) begin
            fail_check("rst_n was never released");
        end
        tick();
        check_bit("fpga_tx", 1'b1, fpga_tx);
        check_bit("led_busy", 1'b0, led_busy);
        check_bit("led_capture", 1'b0, led_capture);
        check_bit("rx_err", 1'b0, rx_err);
        check_bit("comp_in", 1'b0, comp_in);
        end_test();

        begin_test("comp_feedback");
        lvds_mode = 1;
        for (int i = 0; i < 64; i++) begin
            tick();
            check_bit("comp_in", ~prev2, comp_in); // Two syncs behind
        end
        end_test();

        run_dump(0);
        run_dump(32);
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            run_dump(int'(rng % 33));
        end

        begin_test("ignore_byte");
        rng = xorshift32(rng);
        b = rng[15:8];
        if (b == scope_pkg::cmd_dump) begin
            b = ~b;
        end
        send_byte(b, 1'b1);
        expect_quiet(3 * dump_cycles);
        end_test();

        begin_test("framing_error");
        rng = xorshift32(rng);
        k_cur = int'(rng % 33);
        send_byte(scope_pkg::cmd_dump, 1'b0);
        wait_rx_err();
        expect_quiet(dump_cycles);
        send_byte(scope_pkg::cmd_dump, 1'b1);
        recv_line(k_cur);
        wait_busy(1'b0);
        check_bit("rx_err", 1'b0, rx_err);
        end_test();

        begin_test("busy_ignore");
        rng = xorshift32(rng);
        k_cur = int'(rng % 33);
        send_byte(scope_pkg::cmd_dump, 1'b1);
        wait_busy(1'b1);
        send_byte(scope_pkg::cmd_dump, 1'b1); // Lands while capture runs
        check_bit("led_busy", 1'b1, led_busy);
        recv_line(k_cur);
        wait_busy(1'b0);
        expect_quiet(3 * dump_cycles);
        end_test();

        $display("tests passed %0d failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
common/scope_pkg.sv
digitizer/digitizer.sv
design/acia_rx.sv
design/acia_tx.sv
design/sample_capture.sv
hex_dump/hex_dump.sv
design/scope_top.sv
tests/tb_clock.sv
tests/tb_scope.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the scope testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f files.f --top-module tb_scope -o tb_scope
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_scope > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi

exit 0
